//--- Bender.yml
package:
  name: pipeline_ctrl

sources:
  - isa_pkg.sv
  - hazard_pkg.sv
  - dependency_check.sv
  - stage_tracker.sv
  - pc_unit.sv
  - hazard_unit.sv
  - pipeline_ctrl_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - pipeline_ctrl_tb.sv

//--- dependency_check.sv
`timescale 1ns/100ps

module dependency_check (
    input  isa_pkg::instr_desc_t id_instr,   // op in ID
    input  hazard_pkg::slot_t    ex_slot,    // op in EX
    input  hazard_pkg::slot_t    mem_slot,   // op in MEM
    output logic                 data_hazard // ID must wait this cycle
);
    import isa_pkg::*;
    import hazard_pkg::*;

    logic ex_conflict;                       // ID reads what EX will write
    logic mem_conflict;                      // ID reads what MEM will write

    // true when a real, writing op in the slot targets one of the valid sources
    function automatic logic reads_dest(instr_desc_t instr, slot_t slot);
        logic hit1;
        logic hit2;
        hit1 = instr.src1_valid && (instr.src1_idx == slot.dest_idx);
        hit2 = instr.src2_valid && (instr.src2_idx == slot.dest_idx);
        return slot.reg_write && !slot.no_op && (hit1 || hit2);
    endfunction

    assign ex_conflict  = reads_dest(id_instr, ex_slot);
    assign mem_conflict = reads_dest(id_instr, mem_slot);

    // branches resolve in ID so any pending write blocks them,
    // an ALU op only waits on a load still in EX (forwarding covers the rest)
    assign data_hazard = (id_instr.branch && (ex_conflict || mem_conflict)) ||
                         (ex_slot.mem_read && ex_conflict);

endmodule

//--- hazard_pkg.sv
package hazard_pkg;

    // per-stage register action, applied on the next rising edge
    typedef enum logic [1:0] {
        NORMAL = 2'd0,                          // take the value of the stage before
        HOLD   = 2'd1,                          // keep the current value
        NO_OP  = 2'd2                           // load a bubble
    } stage_ctrl_e;

    // what the pipeline is currently dealing with, also shown on the display
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        DATA   = 3'd1,                          // load-use or branch operand not ready
        PAUSE  = 3'd2,                          // user pause, uart rewrite allowed
        UART   = 3'd3,                          // pc ran off the end, waiting for reload
        KEYPAD = 3'd4                           // waiting for user input
    } issue_e;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,                       // one cycle after reset
        EXECUTE   = 2'd1,                       // normal flow
        HAZARD    = 2'd2,                       // data, pause or uart in progress
        INTERRUPT = 2'd3                        // keypad freeze
    } cpu_state_e;

    // one tracked pipeline stage, only what hazard detection needs
    typedef struct packed {
        isa_pkg::reg_idx_t dest_idx;            // register this op will write
        logic              reg_write;           // write-back enabled
        logic              mem_read;            // op is a load
        logic              input_req;           // op wants keypad data in MEM
        logic              no_op;               // stage holds a bubble
    } slot_t;

    typedef struct packed {
        stage_ctrl_e if_ctrl;                   // IF/ID register
        stage_ctrl_e id_ctrl;                   // ID stage, also the consume strobe
        stage_ctrl_e ex_ctrl;
        stage_ctrl_e mem_ctrl;
        stage_ctrl_e wb_ctrl;
    } stage_ctrl_t;

    localparam slot_t SLOT_BUBBLE = '{dest_idx: '0, reg_write: 1'b0, mem_read: 1'b0,
                                      input_req: 1'b0, no_op: 1'b1};

    localparam stage_ctrl_t CTRL_ALL_NORMAL = '{NORMAL, NORMAL, NORMAL, NORMAL, NORMAL};
    localparam stage_ctrl_t CTRL_ALL_HOLD   = '{HOLD, HOLD, HOLD, HOLD, HOLD};

endpackage

//--- hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    data_hazard,     // from dependency_check
    input  logic                    uart_hazard,     // from pc_unit, next fetch out of range
    input  logic                    input_enable,    // from stage_tracker, MEM op wants keypad
    input  logic                    cpu_pause,       // user pause key
    input  logic                    uart_complete,   // reload finished
    input  logic                    input_complete,  // user pressed enter
    output hazard_pkg::stage_ctrl_t ctrl,            // per-stage register action
    output hazard_pkg::issue_e      issue_type,      // for the display
    output logic                    uart_disable,    // low lets the uart write the memories
    output logic                    pc_reset         // one cycle pulse, pc back to 0
);
    import hazard_pkg::*;

    cpu_state_e state_q;
    cpu_state_e state_d;
    issue_e     issue_q;                             // issue being served
    issue_e     issue_d;
    logic       exec_mode;                           // free to pick up a new issue this cycle
    logic       reload_issue;                        // pause or uart wait in progress
    logic       resolved;                            // pause or uart ends this cycle

    // A data stall is transient: it lasts exactly as long as data_hazard is up,
    // so while serving DATA the unit keeps checking every issue like EXECUTE does.
    assign reload_issue = (issue_q == PAUSE) || (issue_q == UART);
    assign exec_mode    = (state_q == EXECUTE) || (state_q == HAZARD && !reload_issue);
    assign resolved     = ((issue_q == UART) && uart_complete) ||
                          ((issue_q == PAUSE) && !cpu_pause && uart_complete);

    always_comb begin
        state_d      = state_q;
        issue_d      = issue_q;
        ctrl         = CTRL_ALL_NORMAL;
        issue_type   = issue_q;
        uart_disable = 1'b1;
        pc_reset     = 1'b0;

        if (state_q == IDLE) begin
            ctrl       = CTRL_ALL_HOLD;              // nothing moves right after reset
            issue_type = NONE;
            state_d    = EXECUTE;
            issue_d    = NONE;
        end else if (state_q == INTERRUPT) begin
            issue_type = KEYPAD;
            if (input_complete) begin
                ctrl    = CTRL_ALL_NORMAL;           // release everything on this edge
                state_d = EXECUTE;
                issue_d = NONE;
            end else begin
                ctrl = CTRL_ALL_HOLD;                // freeze, the input op stays in MEM
            end
        end else if (exec_mode) begin
            // priority: data, pause, uart, keypad
            issue_type = NONE;
            state_d    = EXECUTE;
            issue_d    = NONE;
            if (data_hazard) begin
                ctrl.if_ctrl = HOLD;                 // keep the fetched op
                ctrl.id_ctrl = HOLD;                 // consumer waits in ID
                ctrl.ex_ctrl = NO_OP;                // bubble goes into EX
                issue_type   = DATA;
                state_d      = HAZARD;
                issue_d      = DATA;
            end else if (cpu_pause) begin
                ctrl.if_ctrl = NO_OP;                // drain, older ops finish
                uart_disable = 1'b0;
                issue_type   = PAUSE;
                state_d      = HAZARD;
                issue_d      = PAUSE;
            end else if (uart_hazard) begin
                ctrl.if_ctrl = NO_OP;
                uart_disable = 1'b0;
                issue_type   = UART;
                state_d      = HAZARD;
                issue_d      = UART;
            end else if (input_enable) begin
                ctrl       = CTRL_ALL_HOLD;
                issue_type = KEYPAD;
                state_d    = INTERRUPT;
                issue_d    = KEYPAD;
            end
        end else begin
            // HAZARD serving PAUSE or UART
            ctrl.if_ctrl = NO_OP;                    // keep feeding bubbles
            uart_disable = 1'b0;
            if (resolved) begin
                uart_disable = 1'b1;                 // memories back to cpu side
                pc_reset     = 1'b1;                 // restart from address 0
                state_d      = EXECUTE;
                issue_d      = NONE;
            end else if ((issue_q == UART) && cpu_pause) begin
                issue_type = PAUSE;                  // now the user decides when to resume
                issue_d    = PAUSE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            issue_q <= NONE;
        end else begin
            state_q <= state_d;
            issue_q <= issue_d;
        end
    end

endmodule

//--- isa_pkg.sv
package isa_pkg;

    localparam int REG_IDX_W = 5;               // 32 architectural registers
    localparam int PC_W      = 32;              // byte address into instruction memory

    typedef logic [REG_IDX_W-1:0] reg_idx_t;    // register file index
    typedef logic [PC_W-1:0]      pc_t;         // fetch address

    localparam pc_t PC_STEP = pc_t'(4);         // one 32-bit instruction per fetch

    // Decoded view of the instruction that currently sits in ID.
    // Only the fields that the pipeline control looks at are kept.
    typedef struct packed {
        reg_idx_t src1_idx;                     // first source register
        logic     src1_valid;                   // src1 is really read by this op
        reg_idx_t src2_idx;                     // second source register
        logic     src2_valid;                   // src2 is really read by this op
        reg_idx_t dest_idx;                     // destination register
        logic     reg_write;                    // op writes dest_idx back
        logic     mem_read;                     // load, data comes late from MEM
        logic     branch;                       // compare happens in ID, needs operands early
        logic     input_req;                    // needs keypad data once it reaches MEM
    } instr_desc_t;

endpackage

//--- pc_unit.sv
`timescale 1ns/100ps

module pc_unit #(
    parameter isa_pkg::pc_t PC_MAX = 32'd255         // last valid instruction address
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hazard_pkg::stage_ctrl_e if_ctrl,         // advance only on NORMAL
    input  logic                    pc_reset,        // restart after a reload
    output isa_pkg::pc_t            pc,              // current fetch address
    output logic                    uart_hazard      // next fetch is past the end
);
    import isa_pkg::*;
    import hazard_pkg::*;

    logic [PC_W:0] pc_next;                          // extra bit so the compare never wraps

    assign pc_next     = {1'b0, pc} + {1'b0, PC_STEP};
    assign uart_hazard = pc_next > {1'b0, PC_MAX};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_reset) begin
            pc <= '0;                                // wins over any stage control
        end else if (if_ctrl == NORMAL) begin
            pc <= pc_next[PC_W-1:0];
        end
        // HOLD and NO_OP keep the address, fetch is stalled or drained
    end

endmodule

//--- pipeline_ctrl_tb.sv
`timescale 1ns/100ps

module pipeline_ctrl_tb;
    import isa_pkg::*;
    import hazard_pkg::*;

    localparam pc_t TB_PC_MAX      = 32'd63;           // overflow after 16 fetches
    localparam int  NUM_TESTS      = 6;
    localparam int  RANDOM_CYCLES  = 1500;
    localparam int  TIMEOUT_CYCLES = NUM_TESTS * 400;
    localparam int  SEED           = 94;

    logic        clk;
    logic        rst_n;
    instr_desc_t id_instr;
    logic        cpu_pause;
    logic        uart_complete;
    logic        input_complete;
    pc_t         pc;
    stage_ctrl_t ctrl;
    issue_e      issue_type;
    logic        uart_disable;

    cpu_state_e  m_state;                              // model registers
    issue_e      m_issue;
    slot_t       m_ex;
    slot_t       m_mem;
    pc_t         m_pc;
    stage_ctrl_t e_ctrl;                               // predictions for this cycle
    issue_e      e_issue;
    logic        e_udis;
    logic        e_pcrst;
    cpu_state_e  n_state;
    issue_e      n_issue;
    stage_ctrl_t s_ctrl;                               // DUT outputs at the last sample
    issue_e      s_issue;
    logic        s_udis;
    pc_t         s_pc;
    logic        s_consumed;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) i_clock_gen (.clk(clk), .rst_n(rst_n));

    pipeline_ctrl_top #(
        .PC_MAX (TB_PC_MAX)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_instr       (id_instr),
        .cpu_pause      (cpu_pause),
        .uart_complete  (uart_complete),
        .input_complete (input_complete),
        .pc             (pc),
        .ctrl           (ctrl),
        .issue_type     (issue_type),
        .uart_disable   (uart_disable)
    );

    function automatic instr_desc_t make_instr(reg_idx_t s1, logic v1, reg_idx_t s2, logic v2,
                                               reg_idx_t dst, logic wr, logic ld, logic br,
                                               logic kp);
        instr_desc_t d;
        d = '{src1_idx: s1, src1_valid: v1, src2_idx: s2, src2_valid: v2, dest_idx: dst,
              reg_write: wr, mem_read: ld, branch: br, input_req: kp};
        return d;
    endfunction

    // indices kept to r0..r7 so conflicts come often
    function automatic instr_desc_t random_instr();
        return make_instr(reg_idx_t'($urandom_range(7)), 1'($urandom_range(1)),
                          reg_idx_t'($urandom_range(7)), 1'($urandom_range(1)),
                          reg_idx_t'($urandom_range(7)), 1'($urandom_range(1)),
                          $urandom_range(3) == 0, $urandom_range(3) == 0,
                          $urandom_range(15) == 0);
    endfunction

    function automatic logic depends_on(instr_desc_t d, slot_t s);
        logic hit;
        hit = (d.src1_valid && d.src1_idx == s.dest_idx) ||
              (d.src2_valid && d.src2_idx == s.dest_idx);
        return hit && s.reg_write && !s.no_op;      // bubbles and non-writers never block
    endfunction

    function automatic slot_t slot_from(instr_desc_t d);
        return '{dest_idx: d.dest_idx, reg_write: d.reg_write, mem_read: d.mem_read,
                 input_req: d.input_req, no_op: 1'b0};
    endfunction

    function automatic slot_t apply_ctrl(stage_ctrl_e c, slot_t cur, slot_t prev);
        if (c == NORMAL)
            return prev;
        else if (c == NO_OP)
            return SLOT_BUBBLE;
        return cur;                                 // hold
    endfunction

    // expected controls from the model state and the live inputs
    task automatic predict(input instr_desc_t d, input logic pause, input logic ucomp,
                           input logic icomp);
        logic dh;
        logic uh;
        logic kp;
        dh = (d.branch && (depends_on(d, m_ex) || depends_on(d, m_mem))) ||
             (m_ex.mem_read && depends_on(d, m_ex));
        uh = ({1'b0, m_pc} + 33'd4) > {1'b0, TB_PC_MAX};
        kp = m_mem.input_req && !m_mem.no_op;
        e_ctrl  = CTRL_ALL_NORMAL;
        e_issue = m_issue;
        e_udis  = 1'b1;
        e_pcrst = 1'b0;
        n_state = m_state;
        n_issue = m_issue;
        if (m_state == IDLE) begin
            e_ctrl  = CTRL_ALL_HOLD;
            e_issue = NONE;
            n_state = EXECUTE;
        end else if (m_state == INTERRUPT) begin
            if (!icomp)
                e_ctrl = CTRL_ALL_HOLD;             // frozen until the key arrives
            n_state = icomp ? EXECUTE : INTERRUPT;
            n_issue = icomp ? NONE : KEYPAD;
        end else if (m_issue == PAUSE || m_issue == UART) begin
            e_ctrl.if_ctrl = NO_OP;                 // drain
            e_udis         = 1'b0;
            if (ucomp && (m_issue == UART || !pause)) begin
                e_udis  = 1'b1;
                e_pcrst = 1'b1;
                n_state = EXECUTE;
                n_issue = NONE;
            end else if (pause) begin
                e_issue = PAUSE;                    // pause takes over a reload wait
                n_issue = PAUSE;
            end
        end else begin
            // data stall re-evaluated every cycle, same as EXECUTE
            e_issue = dh ? DATA : pause ? PAUSE : uh ? UART : kp ? KEYPAD : NONE;
            n_issue = e_issue;
            n_state = (e_issue == NONE) ? EXECUTE : (e_issue == KEYPAD) ? INTERRUPT : HAZARD;
            if (e_issue == DATA) begin
                e_ctrl.if_ctrl = HOLD;
                e_ctrl.id_ctrl = HOLD;
                e_ctrl.ex_ctrl = NO_OP;
            end else if (e_issue == PAUSE || e_issue == UART) begin
                e_ctrl.if_ctrl = NO_OP;
                e_udis         = 1'b0;
            end else if (e_issue == KEYPAD) begin
                e_ctrl = CTRL_ALL_HOLD;
            end
        end
    endtask

    task automatic advance_model(input instr_desc_t d);
        slot_t ex_in;
        ex_in = (e_ctrl.id_ctrl == NORMAL) ? slot_from(d) : SLOT_BUBBLE;
        m_mem = apply_ctrl(e_ctrl.mem_ctrl, m_mem, m_ex);  // oldest first, uses old values
        m_ex  = apply_ctrl(e_ctrl.ex_ctrl, m_ex, ex_in);
        if (e_pcrst)
            m_pc = '0;
        else if (e_ctrl.if_ctrl == NORMAL)
            m_pc = m_pc + 32'd4;
        m_state = n_state;
        m_issue = n_issue;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic run_cycle(input instr_desc_t d, input logic pause, input logic ucomp,
                             input logic icomp);
        id_instr       = d;
        cpu_pause      = pause;
        uart_complete  = ucomp;
        input_complete = icomp;
        predict(d, pause, ucomp, icomp);
        #40;                                        // outputs settled, edge still ahead
        s_ctrl     = ctrl;
        s_issue    = issue_type;
        s_udis     = uart_disable;
        s_pc       = pc;
        s_consumed = (ctrl.id_ctrl == NORMAL);
        check_value("ctrl", ctrl, e_ctrl);
        check_value("issue_type", issue_type, e_issue);
        check_value("uart_disable", uart_disable, e_udis);
        check_value("pc", pc, m_pc);
        advance_model(d);
        @(negedge clk);
    endtask

    // keeps the descriptor on id_instr until the DUT takes it
    task automatic issue_instr(input instr_desc_t d, output int stalls);
        stalls = 0;
        run_cycle(d, 1'b0, 1'b0, 1'b0);
        while (!s_consumed) begin
            stalls++;
            run_cycle(d, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        $display("test %0d %s: %s (%0d mismatches)", num, name,
                 (error_count == err_start) ? "ok" : "bad", error_count - err_start);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        instr_desc_t nop;
        instr_desc_t cur;
        int          stalls;
        int          err_start;
        int          seed_sink;
        id_instr       = '0;
        cpu_pause      = 1'b0;
        uart_complete  = 1'b0;
        input_complete = 1'b0;
        seed_sink      = $urandom(SEED);
        nop            = make_instr(0, 0, 0, 0, 0, 0, 0, 0, 0);
        m_state        = IDLE;
        m_issue        = NONE;
        m_ex           = SLOT_BUBBLE;
        m_mem          = SLOT_BUBBLE;
        m_pc           = '0;

        err_start = error_count;
        repeat (2) @(posedge clk);
        #10;                                        // inside reset
        check_value("ctrl", ctrl, CTRL_ALL_HOLD);
        check_value("issue_type", issue_type, NONE);
        check_value("uart_disable", uart_disable, 1'b1);
        check_value("pc", pc, 32'd0);
        wait (rst_n === 1'b1);                      // released on a falling edge
        run_cycle(nop, 1'b0, 1'b0, 1'b0);           // the IDLE cycle
        check_value("ctrl", s_ctrl, CTRL_ALL_HOLD);
        repeat (3) begin
            issue_instr(nop, stalls);
            check_value("start stalls", stalls, 0);
        end
        report_test(1, "reset and start", err_start);

        err_start = error_count;
        issue_instr(make_instr(0, 0, 0, 0, 3, 1, 1, 0, 0), stalls);  // load r3
        issue_instr(make_instr(3, 1, 0, 0, 4, 1, 0, 0, 0), stalls);  // uses r3
        check_value("load-use stalls", stalls, 1);
        issue_instr(make_instr(0, 0, 0, 0, 5, 1, 0, 0, 0), stalls);  // writes r5
        issue_instr(make_instr(1, 1, 5, 1, 0, 0, 0, 1, 0), stalls);  // branch on r5
        check_value("branch ex stalls", stalls, 2);
        issue_instr(make_instr(0, 0, 0, 0, 6, 1, 0, 0, 0), stalls);  // writes r6
        issue_instr(nop, stalls);
        issue_instr(make_instr(6, 1, 0, 0, 0, 0, 0, 1, 0), stalls);  // producer now in MEM
        check_value("branch mem stalls", stalls, 1);
        report_test(2, "data hazards", err_start);

        err_start = error_count;
        while (pc !== 32'd60)
            run_cycle(nop, 1'b0, 1'b0, 1'b0);
        run_cycle(nop, 1'b0, 1'b0, 1'b0);
        check_value("issue_type", s_issue, UART);
        check_value("uart_disable", s_udis, 1'b0);
        repeat (2) run_cycle(nop, 1'b0, 1'b0, 1'b0);
        run_cycle(nop, 1'b0, 1'b1, 1'b0);           // reload done
        run_cycle(nop, 1'b0, 1'b0, 1'b0);
        check_value("pc", s_pc, 32'd0);
        check_value("uart_disable", s_udis, 1'b1);
        report_test(3, "pc overflow", err_start);

        err_start = error_count;
        run_cycle(nop, 1'b1, 1'b0, 1'b0);
        check_value("issue_type", s_issue, PAUSE);
        check_value("uart_disable", s_udis, 1'b0);
        run_cycle(nop, 1'b1, 1'b1, 1'b0);           // still held by the key
        check_value("issue_type", s_issue, PAUSE);
        run_cycle(nop, 1'b0, 1'b0, 1'b0);
        run_cycle(nop, 1'b0, 1'b1, 1'b0);
        run_cycle(nop, 1'b0, 1'b0, 1'b0);
        check_value("issue_type", s_issue, NONE);
        check_value("uart_disable", s_udis, 1'b1);
        issue_instr(make_instr(0, 0, 0, 0, 2, 1, 1, 0, 0), stalls);  // load r2
        run_cycle(make_instr(2, 1, 0, 0, 7, 1, 0, 0, 0), 1'b1, 1'b0, 1'b0);
        check_value("issue_type", s_issue, DATA);   // data beats pause
        run_cycle(make_instr(2, 1, 0, 0, 7, 1, 0, 0, 0), 1'b1, 1'b0, 1'b0);
        check_value("issue_type", s_issue, PAUSE);
        run_cycle(nop, 1'b0, 1'b1, 1'b0);
        while (pc !== 32'd60)
            run_cycle(nop, 1'b0, 1'b0, 1'b0);
        run_cycle(nop, 1'b0, 1'b0, 1'b0);
        check_value("issue_type", s_issue, UART);
        run_cycle(nop, 1'b1, 1'b0, 1'b0);
        check_value("issue_type", s_issue, PAUSE);  // pause raised during reload
        run_cycle(nop, 1'b0, 1'b1, 1'b0);
        run_cycle(nop, 1'b0, 1'b0, 1'b0);
        check_value("pc", s_pc, 32'd0);
        report_test(4, "pause", err_start);

        err_start = error_count;
        issue_instr(make_instr(0, 0, 0, 0, 0, 0, 0, 0, 1), stalls);  // wants keypad data
        issue_instr(nop, stalls);
        repeat (3) begin
            run_cycle(nop, 1'b0, 1'b0, 1'b0);
            check_value("ctrl", s_ctrl, CTRL_ALL_HOLD);
            check_value("issue_type", s_issue, KEYPAD);
        end
        run_cycle(nop, 1'b0, 1'b0, 1'b1);
        check_value("ctrl", s_ctrl, CTRL_ALL_NORMAL);
        report_test(5, "keypad freeze", err_start);

        err_start = error_count;
        cur = random_instr();
        repeat (RANDOM_CYCLES) begin
            run_cycle(cur, $urandom_range(15) == 0, $urandom_range(3) == 0,
                      $urandom_range(3) == 0);
            if (s_consumed)
                cur = random_instr();               // new descriptor only after a take
        end
        report_test(6, "random run", err_start);

        $display("checks: %0d, mismatches: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- pipeline_ctrl_top.f
isa_pkg.sv
hazard_pkg.sv
dependency_check.sv
stage_tracker.sv
pc_unit.sv
hazard_unit.sv
pipeline_ctrl_top.sv
tb_clock_gen.sv
pipeline_ctrl_tb.sv

//--- pipeline_ctrl_top.sv
`timescale 1ns/100ps

module pipeline_ctrl_top #(
    parameter isa_pkg::pc_t PC_MAX = 32'd255      // end of instruction memory
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  isa_pkg::instr_desc_t    id_instr,      // op in ID
    input  logic                    cpu_pause,
    input  logic                    uart_complete,
    input  logic                    input_complete,
    output isa_pkg::pc_t            pc,
    output hazard_pkg::stage_ctrl_t ctrl,
    output hazard_pkg::issue_e      issue_type,
    output logic                    uart_disable
);
    import hazard_pkg::*;

    slot_t ex_slot;                                // tracked EX destination
    slot_t mem_slot;                               // tracked MEM destination
    logic  data_hazard;
    logic  uart_hazard;
    logic  input_enable;
    logic  pc_reset;

    hazard_unit i_hazard_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_hazard    (data_hazard),
        .uart_hazard    (uart_hazard),
        .input_enable   (input_enable),
        .cpu_pause      (cpu_pause),
        .uart_complete  (uart_complete),
        .input_complete (input_complete),
        .ctrl           (ctrl),
        .issue_type     (issue_type),
        .uart_disable   (uart_disable),
        .pc_reset       (pc_reset)
    );

    dependency_check i_dependency_check (
        .id_instr    (id_instr),
        .ex_slot     (ex_slot),
        .mem_slot    (mem_slot),
        .data_hazard (data_hazard)
    );

    stage_tracker i_stage_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_instr     (id_instr),
        .ctrl         (ctrl),
        .ex_slot      (ex_slot),
        .mem_slot     (mem_slot),
        .input_enable (input_enable)
    );

    pc_unit #(
        .PC_MAX (PC_MAX)
    ) i_pc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .if_ctrl     (ctrl.if_ctrl),               // only the fetch field moves the pc
        .pc_reset    (pc_reset),
        .pc          (pc),
        .uart_hazard (uart_hazard)
    );

endmodule

//--- stage_tracker.sv
`timescale 1ns/100ps

module stage_tracker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  isa_pkg::instr_desc_t    id_instr,     // op in ID, consumed when id is NORMAL
    input  hazard_pkg::stage_ctrl_t ctrl,         // from hazard_unit
    output hazard_pkg::slot_t       ex_slot,
    output hazard_pkg::slot_t       mem_slot,
    output logic                    input_enable  // MEM op needs keypad data
);
    import isa_pkg::*;
    import hazard_pkg::*;

    slot_t ex_in;                                 // what EX takes on NORMAL

    // keep only what hazard detection needs from the ID descriptor
    function automatic slot_t to_slot(instr_desc_t instr);
        slot_t s;
        s.dest_idx  = instr.dest_idx;
        s.reg_write = instr.reg_write;
        s.mem_read  = instr.mem_read;
        s.input_req = instr.input_req;
        s.no_op     = 1'b0;
        return s;
    endfunction

    // same register rule for every stage
    function automatic slot_t step_slot(stage_ctrl_e c, slot_t cur, slot_t prev);
        case (c)
            NORMAL:  return prev;                 // advance
            NO_OP:   return SLOT_BUBBLE;          // squash
            default: return cur;                  // hold
        endcase
    endfunction

    // an op that is not consumed stays in ID, so EX must not copy it
    assign ex_in = (ctrl.id_ctrl == NORMAL) ? to_slot(id_instr) : SLOT_BUBBLE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_slot  <= SLOT_BUBBLE;              // pipeline starts empty
            mem_slot <= SLOT_BUBBLE;
        end else begin
            ex_slot  <= step_slot(ctrl.ex_ctrl, ex_slot, ex_in);
            mem_slot <= step_slot(ctrl.mem_ctrl, mem_slot, ex_slot); // op leaving MEM retires
        end
    end

    assign input_enable = mem_slot.input_req && !mem_slot.no_op; // bubbles never ask

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,          // full clock period
    parameter int RESET_CYCLES = 4             // rising edges seen with rst_n low
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                        // release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule
